// ==== mesochronous_link.f ====
+incdir+.
noc_link_pkg.sv
link_sync_pkg.sv
tx_period_timer.sv
tx_slot_writer.sv
rx_toggle_sync.sv
rx_read_fsm.sv
rx_flit_stage.sv
mesochronous_link.sv
tb_mesochronous_link.sv

// ==== tb_link_checks.svh ====
`ifndef TB_LINK_CHECKS_SVH
`define TB_LINK_CHECKS_SVH

// right-shifting galois lfsr for x^16 + x^14 + x^13 + x^11 + 1
localparam logic [15:0] lfsr_seed = 16'd81;
localparam logic [15:0] lfsr_taps = 16'hB400;

logic [15:0] lfsr_state = lfsr_seed;

// flits not yet delivered with the oldest at the front
noc_link_pkg::flit_t expected_q[$];

function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
        return (s >> 1) ^ lfsr_taps;
    end
    return s >> 1;
endfunction

// one lfsr step per bit taken
task automatic random_bits(input int n, output logic [31:0] bits);
    int i;
    bits = '0;
    for (i = 0; i < n; i++) begin
        bits[i] = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
    end
endtask

task automatic random_flit(output noc_link_pkg::flit_t f);
    logic [31:0] r;
    random_bits(noc_link_pkg::flit_width, r);
    f = noc_link_pkg::flit_t'(r);
endtask

// one-cycle strobe that returns gap tx_clk cycles after the strobe
task automatic send_flit(input noc_link_pkg::flit_t f, input bit accepted, input int gap);
    @(negedge tx_clk);
    flit_in = f;
    tx_strobe = 1'b1;
    first_write_done = 1'b1;
    if (accepted) begin
        expected_q.push_back(f);
        accepted_count++;
    end
    @(negedge tx_clk);
    tx_strobe = 1'b0;
    repeat (gap - 2) @(negedge tx_clk);
endtask

// holds the sender to at most three unread flits
task automatic wait_for_room(input int limit);
    int cycles;
    cycles = 0;
    while (expected_q.size() >= 3 && cycles < limit) begin
        @(negedge tx_clk);
        cycles++;
    end
    if (expected_q.size() >= 3) begin
        $display("timeout: receiver kept %0d flits outstanding, flit %h never arrived",
                 expected_q.size(), expected_q[0]);
        error_count++;
        expected_q.delete();
    end
endtask

task automatic wait_drain(input string what, input int limit);
    int cycles;
    cycles = 0;
    while (expected_q.size() != 0 && cycles < limit) begin
        @(posedge clk);
        cycles++;
    end
    if (expected_q.size() != 0) begin
        $display("timeout in %s: flit %h never arrived, %0d flits still outstanding",
                 what, expected_q[0], expected_q.size());
        error_count++;
        expected_q.delete();
    end
endtask

task automatic report_test(input int num, input string name, input int errs_before);
    tests_run++;
    $display("test %0d %s: %0s, %0d errors", num, name,
             (error_count == errs_before) ? "pass" : "fail", error_count - errs_before);
endtask

// nothing leaves the link before the first write
idle_before_write: assert property (@(posedge clk) disable iff (!rst_n)
    !first_write_done |-> (!data_valid && flit_out == '0))
    else begin
        $display("FAIL t=%0t: output active before any write", $time);
        error_count++;
    end

valid_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    data_valid |=> !data_valid)
    else begin
        $display("FAIL t=%0t: data_valid high for two cycles", $time);
        error_count++;
        double_valid_errors++;
    end

// flit_out may only move together with a valid pulse
flit_holds: assert property (@(posedge clk) disable iff (!rst_n)
    !data_valid |-> $stable(flit_out))
    else begin
        $display("FAIL t=%0t: flit_out changed without data_valid", $time);
        error_count++;
    end

`endif

// ==== tb_mesochronous_link.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mesochronous_link;

    localparam int clk_half    = 4;
    localparam int tx_offset   = 3;
    localparam int drain_limit = 200;

    logic                   clk;
    logic                   tx_clk;
    logic                   rst_n;
    noc_link_pkg::flit_t    flit_in;
    logic                   tx_strobe;
    logic                   link_active;
    logic                   alert;
    link_sync_pkg::period_t tx_period;
    noc_link_pkg::flit_t    flit_out;
    logic                   data_valid;

    int   error_count = 0;
    int   tests_run = 0;
    int   delivered_count = 0;
    int   valid_pulses = 0;
    int   double_valid_errors = 0;
    int   accepted_count = 0;
    logic first_write_done = 1'b0;

    `include "tb_link_checks.svh"

    mesochronous_link mesochronous_link_inst (
        .clk         (clk),
        .tx_clk      (tx_clk),
        .rst_n       (rst_n),
        .flit_in     (flit_in),
        .tx_strobe   (tx_strobe),
        .link_active (link_active),
        .alert       (alert),
        .tx_period   (tx_period),
        .flit_out    (flit_out),
        .data_valid  (data_valid)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    // same frequency with a fixed phase offset
    initial begin
        tx_clk = 1'b0;
        #tx_offset;
        forever #clk_half tx_clk = ~tx_clk;
    end

    // scoreboard samples on the falling edge where outputs are settled
    always @(negedge clk) begin
        if (rst_n && data_valid) begin
            valid_pulses++;
            assert (expected_q.size() != 0) else begin
                $display("FAIL t=%0t: flit %h delivered with none expected", $time, flit_out);
                error_count++;
            end
            if (expected_q.size() != 0) begin
                assert (flit_out == expected_q[0]) else begin
                    $display("FAIL t=%0t: flit_out %h, expected %h",
                             $time, flit_out, expected_q[0]);
                    error_count++;
                end
                void'(expected_q.pop_front());
                delivered_count++;
            end
        end
    end

    initial begin
        noc_link_pkg::flit_t f;
        logic [31:0]         r;
        int                  errs;
        int                  i;
        int                  burst;

        flit_in     = '0;
        tx_strobe   = 1'b0;
        link_active = 1'b0;
        alert       = 1'b0;
        tx_period   = link_sync_pkg::period_t'(8);
        rst_n       = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge tx_clk);
        rst_n = 1'b1;
        @(negedge tx_clk);
        link_active = 1'b1;

        errs = error_count;
        repeat (20) @(negedge tx_clk);
        report_test(1, "idle after reset", errs);

        errs = error_count;
        for (i = 0; i < 3; i++) begin
            random_flit(f);
            send_flit(f, 1'b1, 4);
        end
        wait_drain("burst of three", drain_limit);
        report_test(2, "burst of three", errs);

        // random spacing of 4 to 7 cycles
        errs = error_count;
        for (i = 0; i < 20; i++) begin
            wait_for_room(drain_limit);
            random_flit(f);
            random_bits(2, r);
            send_flit(f, 1'b1, 4 + int'(r[1:0]));
        end
        wait_drain("random stream", drain_limit);
        report_test(3, "random stream", errs);

        // two full periods of alert close the write path at a head
        errs = error_count;
        @(negedge tx_clk);
        alert = 1'b1;
        repeat (16) @(negedge tx_clk);
        for (i = 0; i < 2; i++) begin
            random_flit(f);
            send_flit(f, 1'b0, 4);
        end
        alert = 1'b0;
        repeat (16) @(negedge tx_clk);
        for (i = 0; i < 2; i++) begin
            random_flit(f);
            send_flit(f, 1'b1, 4);
        end
        wait_drain("alert throttle", drain_limit);
        report_test(4, "alert throttle", errs);

        // odd burst sized so both pointers stop away from slot 0
        errs = error_count;
        burst = ((accepted_count + 3) % 4 == 0) ? 1 : 3;
        for (i = 0; i < burst; i++) begin
            random_flit(f);
            send_flit(f, 1'b1, 4);
        end
        wait_drain("burst before link drop", drain_limit);
        @(negedge tx_clk);
        link_active = 1'b0;
        repeat (10) @(negedge tx_clk);
        link_active = 1'b1;
        for (i = 0; i < 3; i++) begin
            random_flit(f);
            send_flit(f, 1'b1, 4);
        end
        wait_drain("burst after link drop", drain_limit);
        report_test(5, "link drop restart", errs);

        tests_run++;
        $display("test 6 single-cycle valid: %0s, %0d pulses seen",
                 (double_valid_errors == 0) ? "pass" : "fail", valid_pulses);

        $display("tests %0d, flits delivered %0d, errors %0d",
                 tests_run, delivered_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mesochronous_link.sv ====
`timescale 1ns/1ps
`default_nettype none

module mesochronous_link (
    input  wire                           clk,
    input  wire                           tx_clk,
    input  wire                           rst_n,
    input  wire noc_link_pkg::flit_t      flit_in,
    input  wire                           tx_strobe,
    input  wire                           link_active,
    input  wire                           alert,
    input  wire link_sync_pkg::period_t   tx_period,
    output noc_link_pkg::flit_t           flit_out,
    output logic                          data_valid
);

    logic                       pass_enable;
    link_sync_pkg::slot_bank_t  slot_bank;
    link_sync_pkg::toggle_vec_t slot_change;
    logic                       link_active_sync;
    link_sync_pkg::slot_ptr_t   rd_slot;
    logic                       rd_strobe;

    // transmit clock domain
    tx_period_timer tx_period_timer_inst (
        .tx_clk      (tx_clk),
        .rst_n       (rst_n),
        .link_active (link_active),
        .tx_period   (tx_period),
        .alert       (alert),
        .pass_enable (pass_enable)
    );

    tx_slot_writer tx_slot_writer_inst (
        .tx_clk      (tx_clk),
        .rst_n       (rst_n),
        .tx_strobe   (tx_strobe),
        .link_active (link_active),
        .pass_enable (pass_enable),
        .flit_in     (flit_in),
        .slot_bank   (slot_bank)
    );

    // receive clock domain
    rx_toggle_sync rx_toggle_sync_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .toggles          (slot_bank.toggles),
        .link_active      (link_active),
        .slot_change      (slot_change),
        .link_active_sync (link_active_sync)
    );

    rx_read_fsm rx_read_fsm_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .slot_change      (slot_change),
        .link_active_sync (link_active_sync),
        .rd_slot          (rd_slot),
        .rd_strobe        (rd_strobe)
    );

    rx_flit_stage rx_flit_stage_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .slot_bank  (slot_bank),
        .rd_slot    (rd_slot),
        .rd_strobe  (rd_strobe),
        .flit_out   (flit_out),
        .data_valid (data_valid)
    );

endmodule

`default_nettype wire

// ==== rx_flit_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_flit_stage (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire link_sync_pkg::slot_bank_t   slot_bank,
    input  wire link_sync_pkg::slot_ptr_t    rd_slot,
    input  wire                              rd_strobe,
    output noc_link_pkg::flit_t              flit_out,
    output logic                             data_valid
);

    noc_link_pkg::flit_t sel_flit;

    // slot multiplexer
    always_comb begin
        case (rd_slot)
            2'd0: sel_flit = slot_bank.slots[0];
            2'd1: sel_flit = slot_bank.slots[1];
            2'd2: sel_flit = slot_bank.slots[2];
            2'd3: sel_flit = slot_bank.slots[3];
            default: sel_flit = '0;
        endcase
    end

    // output flit holds between deliveries
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flit_out <= '0;
        end else if (rd_strobe) begin
            flit_out <= sel_flit;
        end
    end

    // one-cycle valid pulse alongside the new flit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_valid <= 1'b0;
        end else begin
            data_valid <= rd_strobe;
        end
    end

endmodule

`default_nettype wire

// ==== rx_read_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_read_fsm (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire link_sync_pkg::toggle_vec_t  slot_change,
    input  wire                              link_active_sync,
    output link_sync_pkg::slot_ptr_t         rd_slot,
    output logic                             rd_strobe
);

    link_sync_pkg::slot_ptr_t rd_slot_next;

    // only the change pulse of the slot we wait on counts
    assign rd_strobe = slot_change[rd_slot];

    always_comb begin
        rd_slot_next = rd_slot;
        case (rd_slot)
            2'd0: begin
                if (rd_strobe) begin
                    rd_slot_next = 2'd1;
                end else if (!link_active_sync) begin
                    rd_slot_next = 2'd0;
                end
            end
            2'd1: begin
                if (rd_strobe) begin
                    rd_slot_next = 2'd2;
                end else if (!link_active_sync) begin
                    rd_slot_next = 2'd0;
                end
            end
            2'd2: begin
                if (rd_strobe) begin
                    rd_slot_next = 2'd3;
                end else if (!link_active_sync) begin
                    rd_slot_next = 2'd0;
                end
            end
            2'd3: begin
                // last slot wraps back to the first
                if (rd_strobe) begin
                    rd_slot_next = 2'd0;
                end else if (!link_active_sync) begin
                    rd_slot_next = 2'd0;
                end
            end
            default: begin
                rd_slot_next = 2'd0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_slot <= '0;
        end else begin
            rd_slot <= rd_slot_next;
        end
    end

endmodule

`default_nettype wire

// ==== rx_toggle_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_toggle_sync (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire link_sync_pkg::toggle_vec_t  toggles,
    input  wire                              link_active,
    output link_sync_pkg::toggle_vec_t       slot_change,
    output logic                             link_active_sync
);

    link_sync_pkg::toggle_vec_t tgl_meta;
    link_sync_pkg::toggle_vec_t tgl_sync;
    link_sync_pkg::toggle_vec_t tgl_hist;
    logic                       active_meta;

    // two-flop synchroniser for the toggles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tgl_meta <= '0;
            tgl_sync <= '0;
        end else begin
            tgl_meta <= toggles;
            tgl_sync <= tgl_meta;
        end
    end

    // previous synchronised value, compared against the new one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tgl_hist <= '0;
        end else begin
            tgl_hist <= tgl_sync;
        end
    end

    // registered change pulse, one cycle per toggle flip
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_change <= '0;
        end else begin
            slot_change <= tgl_sync ^ tgl_hist;
        end
    end

    // link-active level into the receive clock
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_meta      <= 1'b0;
            link_active_sync <= 1'b0;
        end else begin
            active_meta      <= link_active;
            link_active_sync <= active_meta;
        end
    end

endmodule

`default_nettype wire

// ==== tx_slot_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_slot_writer (
    input  wire                       tx_clk,
    input  wire                       rst_n,
    input  wire                       tx_strobe,
    input  wire                       link_active,
    input  wire                       pass_enable,
    input  wire noc_link_pkg::flit_t  flit_in,
    output link_sync_pkg::slot_bank_t slot_bank
);

    link_sync_pkg::slot_ptr_t                                wr_ptr;
    noc_link_pkg::flit_t [link_sync_pkg::num_slots-1:0]      slot_q;
    link_sync_pkg::toggle_vec_t                              toggle_q;
    logic                                                    wr_accept;

    // dropped strobes leave pointer, slots and toggles alone
    assign wr_accept = tx_strobe && pass_enable;

    // round-robin write pointer
    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (wr_accept) begin
            wr_ptr <= link_sync_pkg::slot_ptr_t'(wr_ptr + 1'b1);
        end else if (!link_active) begin
            // idle link restarts at slot 0, same as the reader
            wr_ptr <= '0;
        end
    end

    // slot storage
    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_q <= '0;
        end else if (wr_accept) begin
            slot_q[wr_ptr] <= flit_in;
        end
    end

    // one flip per accepted write, so the receiver sees an edge per flit
    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            toggle_q <= '0;
        end else if (wr_accept) begin
            toggle_q[wr_ptr] <= ~toggle_q[wr_ptr];
        end
    end

    // slot data is already settled by the time its toggle change is seen
    assign slot_bank.slots   = slot_q;
    assign slot_bank.toggles = toggle_q;

endmodule

`default_nettype wire

// ==== tx_period_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_period_timer (
    input  wire                   tx_clk,
    input  wire                   rst_n,
    input  wire                   link_active,
    input  wire link_sync_pkg::period_t tx_period,
    input  wire                   alert,
    output logic                  pass_enable
);

    link_sync_pkg::period_t count;
    logic                   period_head;

    // count runs 1..tx_period while the link is up, 0 when idle
    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!link_active) begin
            count <= '0;
        end else if (count == '0) begin
            count <= link_sync_pkg::period_t'(1);
        end else if (count >= tx_period) begin
            // wrap back to the head of the next period
            count <= link_sync_pkg::period_t'(1);
        end else begin
            count <= link_sync_pkg::period_t'(count + 1'b1);
        end
    end

    // first cycle of each period
    assign period_head = (count == link_sync_pkg::period_t'(1)) && link_active;

    // alert only counts at the period head, the decision then holds
    // for the rest of that period
    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            pass_enable <= 1'b1;
        end else if (period_head) begin
            pass_enable <= ~alert;
        end
    end

endmodule

`default_nettype wire

// ==== link_sync_pkg.sv ====
`default_nettype none

package link_sync_pkg;

    // slot registers between the two clock domains
    localparam int num_slots = 4;
    localparam int slot_ptr_width = $clog2(num_slots);

    // period counter width, periods up to 31 cycles
    localparam int period_width = 5;

    typedef logic [slot_ptr_width-1:0] slot_ptr_t;

    // one toggle bit per slot
    typedef logic [num_slots-1:0] toggle_vec_t;

    typedef logic [period_width-1:0] period_t;

    // everything the writer exposes to the receive side
    typedef struct packed {
        noc_link_pkg::flit_t [num_slots-1:0] slots;
        toggle_vec_t                         toggles;
    } slot_bank_t;

endpackage

`default_nettype wire

// ==== noc_link_pkg.sv ====
`default_nettype none

package noc_link_pkg;

    // one flit is a single 32-bit word on the link
    localparam int flit_width = 32;

    // head and tail markers sit in the top two bits
    localparam int flit_ctrl_bits = 2;
    localparam int flit_body_width = flit_width - flit_ctrl_bits;

    // flit layout, msb first
    typedef struct packed {
        logic                       tail;
        logic                       head;
        logic [flit_body_width-1:0] body;
    } flit_t;

endpackage

`default_nettype wire
